// ==== common/tcdm_pkg.sv ====
// memory port widths, core count and request metadata, shared by the adapter and its testbench
`default_nettype none

package tcdm_pkg;

  // --------------------
  // widths
  // --------------------

  // one memory word, the adapter only supports 32 bits
  localparam int unsigned DataWidth = 32;
  // one enable bit per byte lane
  localparam int unsigned BeWidth = DataWidth / 8;

  // cores that can reach this bank
  localparam int unsigned NumCores = 4;
  // enough bits to name every core
  localparam int unsigned CoreIdWidth = $clog2(NumCores);
  // per-core request tag, echoed back so the core can match responses
  localparam int unsigned TagWidth = 4;

  // --------------------
  // types
  // --------------------

  typedef logic [DataWidth-1:0] data_t;

  // request metadata, returned untouched with the response
  // core_id also keys the lr/sc reservation
  typedef struct packed {
    logic [CoreIdWidth-1:0] core_id;
    logic [TagWidth-1:0]    tag;
  } meta_t;

endpackage

`default_nettype wire

// ==== common/amo_pkg.sv ====
// atomic opcode encoding and opcode classes used by the request control and the reservation logic
`default_nettype none

package amo_pkg;

  // --------------------
  // opcodes
  // --------------------

  // 4-bit opcode carried with every request
  // none marks a plain load or store
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_t;

  // --------------------
  // classes
  // --------------------

  // read-modify-write atomics occupy a contiguous range, swap up to minu
  // these need a locked read followed by a write-back
  function automatic logic is_rmw(amo_op_t op);
    return op inside {[AmoSwap:AmoMinu]};
  endfunction

endpackage

`default_nettype wire

// ==== hw/atomics/amo_alu.sv ====
// combinational atomic arithmetic, combines the old memory word with the request operand
`default_nettype none
`timescale 1ns/1ns

module amo_alu (
  input  amo_pkg::amo_op_t amo_op_i,
  // word read from memory
  input  tcdm_pkg::data_t  operand_a_i,
  // operand sent with the request
  input  tcdm_pkg::data_t  operand_b_i,
  output tcdm_pkg::data_t  result_o
);

  // one extra bit so signed and unsigned compares share the adder
  logic        cmp_signed;
  logic        negate_b;
  logic [32:0] adder_a;
  logic [32:0] adder_b;
  logic [32:0] adder_sum;
  // a below b, valid when negate_b is set
  logic        a_less;

  // --------------------
  // shared adder
  // --------------------

  always_comb begin
    cmp_signed = 1'b0;
    negate_b   = 1'b0;
    unique case (amo_op_i)
      amo_pkg::AmoMax,
      amo_pkg::AmoMin: begin
        cmp_signed = 1'b1;
        negate_b   = 1'b1;
      end
      amo_pkg::AmoMaxu,
      amo_pkg::AmoMinu: begin
        negate_b = 1'b1;
      end
      default: begin
        negate_b = 1'b0;
      end
    endcase
  end

  // sign-extend for signed compares, zero-extend otherwise
  assign adder_a = {cmp_signed & operand_a_i[31], operand_a_i};
  assign adder_b = negate_b ? ~{cmp_signed & operand_b_i[31], operand_b_i}
                            :  {cmp_signed & operand_b_i[31], operand_b_i};

  // two's complement negate by inverting and adding one as carry-in
  assign adder_sum = adder_a + adder_b + {32'b0, negate_b};
  // a - b always fits in 33 bits, so the top bit is its sign
  assign a_less    = adder_sum[32];

  // --------------------
  // result select
  // --------------------

  always_comb begin
    unique case (amo_op_i)
      amo_pkg::AmoAdd:  result_o = adder_sum[31:0];
      amo_pkg::AmoAnd:  result_o = operand_a_i & operand_b_i;
      amo_pkg::AmoOr:   result_o = operand_a_i | operand_b_i;
      amo_pkg::AmoXor:  result_o = operand_a_i ^ operand_b_i;
      amo_pkg::AmoMax,
      amo_pkg::AmoMaxu: result_o = a_less ? operand_b_i : operand_a_i;
      amo_pkg::AmoMin,
      amo_pkg::AmoMinu: result_o = a_less ? operand_a_i : operand_b_i;
      // swap, and the non-atomic codes that never reach a write-back
      default:          result_o = operand_b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/atomics/amo_sequencer.sv ====
// request control that the adapter top level instantiates to drive the sram port and run atomics
`default_nettype none
`timescale 1ns/1ns

module amo_sequencer #(
  parameter int unsigned AddrWidth = 10
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // core request
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic [AddrWidth-1:0]         in_address_i,
  input  amo_pkg::amo_op_t             in_amo_i,
  input  logic                         in_write_i,
  input  tcdm_pkg::data_t              in_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0] in_be_i,
  input  tcdm_pkg::meta_t              in_meta_i,
  // room in the response buffer
  input  logic                         buf_ready_i,
  // same-cycle verdict of the reservation monitor
  input  logic                         sc_success_i,
  // sram port
  output logic                         out_req_o,
  output logic [AddrWidth-1:0]         out_add_o,
  output logic                         out_write_o,
  output tcdm_pkg::data_t              out_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0] out_be_o,
  input  tcdm_pkg::data_t              out_rdata_i,
  // towards monitor and buffers
  output logic                         accept_o,
  output logic                         push_o,
  output tcdm_pkg::data_t              resp_data_o,
  output tcdm_pkg::meta_t              resp_meta_o
);

  typedef enum logic {
    StIdle,
    StWriteBack
  } state_t;

  state_t state_q, state_d;

  // request classes
  logic is_rmw;
  logic is_sc;
  logic is_store;

  // response due next cycle
  logic            resp_due_q;
  logic            sc_q;
  logic            sc_ok_q;
  tcdm_pkg::meta_t meta_q;

  // locked atomic waiting for its write-back
  amo_pkg::amo_op_t     amo_op_q;
  logic [AddrWidth-1:0] amo_addr_q;
  tcdm_pkg::data_t      amo_operand_q;
  tcdm_pkg::data_t      amo_result;

  assign is_rmw   = amo_pkg::is_rmw(in_amo_i);
  assign is_sc    = (in_amo_i == amo_pkg::AmoSc);
  assign is_store = in_write_i & (in_amo_i == amo_pkg::AmoNone);

  // write-back owns the port, and a held response blocks new requests
  assign in_ready_o = (state_q == StIdle) & buf_ready_i;
  assign accept_o   = in_valid_i & in_ready_o;

  // --------------------
  // sram port
  // --------------------

  always_comb begin
    // default is the accepted request itself and atomics start as a plain read
    // a failing sc leaves the port idle
    out_req_o   = accept_o & ~(is_sc & ~sc_success_i);
    out_add_o   = in_address_i;
    out_write_o = accept_o & (is_sc ? sc_success_i : is_store);
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;
    state_d     = state_q;
    unique case (state_q)
      StIdle: begin
        if (accept_o && is_rmw) begin
          state_d = StWriteBack;
        end
      end
      StWriteBack: begin
        // old word is on out_rdata_i now so the alu result is committed
        out_req_o   = 1'b1;
        out_add_o   = amo_addr_q;
        out_write_o = 1'b1;
        out_wdata_o = amo_result;
        out_be_o    = '1;
        state_d     = StIdle;
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  amo_alu i_amo_alu (
    .amo_op_i   (amo_op_q),
    .operand_a_i(out_rdata_i),
    .operand_b_i(amo_operand_q),
    .result_o   (amo_result)
  );

  // --------------------
  // response
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      resp_due_q <= 1'b0;
      sc_q       <= 1'b0;
    end else begin
      state_q    <= state_d;
      // plain stores are silent
      resp_due_q <= accept_o & ~is_store;
      sc_q       <= accept_o & is_sc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      meta_q  <= in_meta_i;
      sc_ok_q <= sc_success_i;
    end
    if (accept_o && is_rmw) begin
      amo_op_q      <= in_amo_i;
      amo_addr_q    <= in_address_i;
      amo_operand_q <= in_wdata_i;
    end
  end

  // sc answers 0 on success and everything else returns the sram word
  assign push_o      = resp_due_q;
  assign resp_meta_o = meta_q;
  assign resp_data_o = sc_q ? {{(tcdm_pkg::DataWidth-1){1'b0}}, ~sc_ok_q} : out_rdata_i;

endmodule

`default_nettype wire

// ==== hw/lrsc_monitor.sv ====
// lr/sc reservation for the bank, one entry keyed by core, decides store-conditional success
`default_nettype none
`timescale 1ns/1ns

module lrsc_monitor #(
  parameter int unsigned AddrWidth = 10
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // request accepted this cycle
  input  logic                             accept_i,
  input  amo_pkg::amo_op_t                 amo_i,
  input  logic [AddrWidth-1:0]             address_i,
  input  logic                             write_i,
  input  logic [tcdm_pkg::CoreIdWidth-1:0] core_id_i,
  // combinational, valid in the acceptance cycle
  output logic                             sc_success_o
);

  // the reservation
  logic                             valid_q, valid_d;
  logic [AddrWidth-1:0]             addr_q, addr_d;
  logic [tcdm_pkg::CoreIdWidth-1:0] core_q, core_d;

  logic is_lr;
  logic is_sc;
  logic own_core;
  logic addr_hit;
  // store or atomic that modifies memory outside lr/sc
  logic modifies;

  assign is_lr    = (amo_i == amo_pkg::AmoLr);
  assign is_sc    = (amo_i == amo_pkg::AmoSc);
  assign own_core = valid_q & (core_q == core_id_i);
  assign addr_hit = (addr_q == address_i);
  assign modifies = amo_pkg::is_rmw(amo_i) | (write_i & (amo_i == amo_pkg::AmoNone));

  // sc from the owner to the reserved word
  assign sc_success_o = accept_i & is_sc & own_core & addr_hit;

  // --------------------
  // next reservation
  // --------------------

  always_comb begin
    valid_d = valid_q;
    addr_d  = addr_q;
    core_d  = core_q;
    if (accept_i) begin
      // no stealing from another core, which avoids live-lock
      if (is_lr && (!valid_q || own_core)) begin
        valid_d = 1'b1;
        addr_d  = address_i;
        core_d  = core_id_i;
      end
      // any other writer to the word breaks it
      if (modifies && addr_hit) begin
        valid_d = 1'b0;
      end
      // owner's sc consumes the reservation whether it succeeds or not
      if (is_sc && own_core) begin
        valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    core_q <= core_d;
  end

endmodule

`default_nettype wire

// ==== hw/resp_buffer.sv ====
// one-entry fall-through buffer that holds a response under back-pressure, payload type set per instance
`default_nettype none
`timescale 1ns/1ns

module resp_buffer #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // push side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // pop side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;
  // capture the pushed entry when it cannot leave this cycle
  logic load;

  // --------------------
  // output side
  // --------------------

  // empty buffer passes the push straight through
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // room means nothing is presented, or what is presented is taken now
  assign ready_o = ~valid_o | ready_i;

  // empty and not popped, or full and the old entry is being popped
  assign load = valid_i & (full_q ? ready_i : ~ready_i);

  // --------------------
  // state
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // stays full unless popped with nothing new behind it
      full_q <= ~ready_i | valid_i;
    end else begin
      full_q <= valid_i & ~ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcdm_adapter.sv ====
// memory bank adapter, place it in front of one SRAM to get atomics, lr/sc and buffered responses
`default_nettype none
`timescale 1ns/1ns

module tcdm_adapter #(
  parameter int unsigned AddrWidth = 10
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // core side, request
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic [AddrWidth-1:0]                 in_address_i,
  input  amo_pkg::amo_op_t                     in_amo_i,
  // high for a store
  input  logic                                 in_write_i,
  input  tcdm_pkg::data_t                      in_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]         in_be_i,
  input  tcdm_pkg::meta_t                      in_meta_i,
  // core side, response
  output logic                                 in_valid_o,
  input  logic                                 in_ready_i,
  output tcdm_pkg::data_t                      in_rdata_o,
  output tcdm_pkg::meta_t                      in_meta_o,
  // sram side, no grant, read data one cycle later
  output logic                                 out_req_o,
  output logic [AddrWidth-1:0]                 out_add_o,
  output logic                                 out_write_o,
  output tcdm_pkg::data_t                      out_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]         out_be_o,
  input  tcdm_pkg::data_t                      out_rdata_i
);

  // handshake between sequencer and reservation monitor
  logic accept;
  logic sc_success;

  // response path into the two buffers
  logic            push;
  logic            buf_ready;
  tcdm_pkg::data_t resp_data;
  tcdm_pkg::meta_t resp_meta;

  // --------------------
  // request control
  // --------------------

  amo_sequencer #(
    .AddrWidth(AddrWidth)
  ) i_amo_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_address_i(in_address_i),
    .in_amo_i    (in_amo_i),
    .in_write_i  (in_write_i),
    .in_wdata_i  (in_wdata_i),
    .in_be_i     (in_be_i),
    .in_meta_i   (in_meta_i),
    .buf_ready_i (buf_ready),
    .sc_success_i(sc_success),
    .out_req_o   (out_req_o),
    .out_add_o   (out_add_o),
    .out_write_o (out_write_o),
    .out_wdata_o (out_wdata_o),
    .out_be_o    (out_be_o),
    .out_rdata_i (out_rdata_i),
    .accept_o    (accept),
    .push_o      (push),
    .resp_data_o (resp_data),
    .resp_meta_o (resp_meta)
  );

  // reservation is keyed by the issuing core only, the tag is ignored
  lrsc_monitor #(
    .AddrWidth(AddrWidth)
  ) i_lrsc_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .amo_i       (in_amo_i),
    .address_i   (in_address_i),
    .write_i     (in_write_i),
    .core_id_i   (in_meta_i.core_id),
    .sc_success_o(sc_success)
  );

  // --------------------
  // response buffers
  // --------------------

  // the data buffer's handshake stands for both buffers
  resp_buffer #(
    .T(tcdm_pkg::data_t)
  ) i_rdata_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(push),
    .ready_o(buf_ready),
    .data_i (resp_data),
    .valid_o(in_valid_o),
    .ready_i(in_ready_i),
    .data_o (in_rdata_o)
  );

  // pushed and popped together with the data buffer, so its handshake is redundant
  resp_buffer #(
    .T(tcdm_pkg::meta_t)
  ) i_meta_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(push),
    .ready_o(),
    .data_i (resp_meta),
    .valid_o(),
    .ready_i(in_ready_i),
    .data_o (in_meta_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_tcdm_adapter.sv ====
// self-checking testbench for the memory bank adapter, compile it as the simulation top with the file list
`default_nettype none
`timescale 1ns/1ns

module tb_tcdm_adapter;

  localparam int unsigned AddrWidth = 10;
  localparam int MemDepth = 2 ** AddrWidth;
  localparam int NumLdSt = 200;
  localparam int NumAmo = 200;
  localparam int NumLrSc = 200;
  localparam int NumMixed = 200;
  // every atomic is followed by a load of the same word
  localparam int NumRequests = NumLdSt + 2 * NumAmo + NumLrSc + NumMixed;
  localparam int CycleLimit = 4 * NumRequests + 100;
  // idle cycles a drain waits for outstanding responses
  localparam int DrainLimit = 20;

  logic clk;
  logic rst_n;

  // core side
  logic                                 req_valid;
  logic                                 req_ready;
  logic [AddrWidth-1:0]                 req_address;
  amo_pkg::amo_op_t                     req_amo;
  logic                                 req_write;
  tcdm_pkg::data_t                      req_wdata;
  logic [tcdm_pkg::BeWidth-1:0]         req_be;
  tcdm_pkg::meta_t                      req_meta;
  logic                                 rsp_valid;
  logic                                 rsp_ready;
  tcdm_pkg::data_t                      rsp_rdata;
  tcdm_pkg::meta_t                      rsp_meta;

  // sram side
  logic                                 sram_req;
  logic [AddrWidth-1:0]                 sram_add;
  logic                                 sram_write;
  tcdm_pkg::data_t                      sram_wdata;
  logic [tcdm_pkg::BeWidth-1:0]         sram_be;
  tcdm_pkg::data_t                      sram_rdata = '0;
  tcdm_pkg::data_t                      sram_mem [MemDepth];

  // reference model: memory, reservation and expected responses in order
  tcdm_pkg::data_t                      ref_mem [8];
  logic                                 res_valid;
  logic [AddrWidth-1:0]                 res_addr;
  logic [tcdm_pkg::CoreIdWidth-1:0]     res_core;
  tcdm_pkg::data_t                      exp_data_q [$];
  tcdm_pkg::meta_t                      exp_meta_q [$];

  logic [31:0] lfsr;
  logic [3:0]  tag_count;
  // randomly stall the response side
  logic        hold_back;
  int          cycles;
  int          errors;
  int          checks;
  int          test_start_errors;

  tcdm_adapter #(
    .AddrWidth(AddrWidth)
  ) i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .in_valid_i  (req_valid),
    .in_ready_o  (req_ready),
    .in_address_i(req_address),
    .in_amo_i    (req_amo),
    .in_write_i  (req_write),
    .in_wdata_i  (req_wdata),
    .in_be_i     (req_be),
    .in_meta_i   (req_meta),
    .in_valid_o  (rsp_valid),
    .in_ready_i  (rsp_ready),
    .in_rdata_o  (rsp_rdata),
    .in_meta_o   (rsp_meta),
    .out_req_o   (sram_req),
    .out_add_o   (sram_add),
    .out_write_o (sram_write),
    .out_wdata_o (sram_wdata),
    .out_be_o    (sram_be),
    .out_rdata_i (sram_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [AddrWidth-1:0] rand_addr(input int bits);
    logic [31:0] r;
    r = take_bits(bits);
    return r[AddrWidth-1:0];
  endfunction

  function automatic logic [tcdm_pkg::CoreIdWidth-1:0] pick_core();
    logic [31:0] r;
    r = take_bits(tcdm_pkg::CoreIdWidth);
    return r[tcdm_pkg::CoreIdWidth-1:0];
  endfunction

  function automatic logic [tcdm_pkg::BeWidth-1:0] byte_mask();
    logic [31:0] r;
    r = take_bits(tcdm_pkg::BeWidth);
    return r[tcdm_pkg::BeWidth-1:0];
  endfunction

  // start value of every word, mixes all address bits
  function automatic tcdm_pkg::data_t fill_word(input int unsigned a);
    return 32'h3c5a_0000 ^ (a * 32'h9e37_79b9);
  endfunction

  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old,
                                                  input tcdm_pkg::data_t wdata,
                                                  input logic [tcdm_pkg::BeWidth-1:0] be);
    tcdm_pkg::data_t r;
    r = old;
    for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
      if (be[b]) begin
        r[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return r;
  endfunction

  // value written back by an atomic, from the instruction definitions
  function automatic tcdm_pkg::data_t amo_result(input amo_pkg::amo_op_t op,
                                                 input tcdm_pkg::data_t mem,
                                                 input tcdm_pkg::data_t opnd);
    case (op)
      amo_pkg::AmoSwap: return opnd;
      amo_pkg::AmoAdd:  return mem + opnd;
      amo_pkg::AmoAnd:  return mem & opnd;
      amo_pkg::AmoOr:   return mem | opnd;
      amo_pkg::AmoXor:  return mem ^ opnd;
      amo_pkg::AmoMax:  return ($signed(mem) > $signed(opnd)) ? mem : opnd;
      amo_pkg::AmoMaxu: return (mem > opnd) ? mem : opnd;
      amo_pkg::AmoMin:  return ($signed(mem) < $signed(opnd)) ? mem : opnd;
      amo_pkg::AmoMinu: return (mem < opnd) ? mem : opnd;
      default:          return mem;
    endcase
  endfunction

  task automatic show_mismatch(input string name, input tcdm_pkg::data_t got,
                               input tcdm_pkg::data_t exp);
    $display("FAILED at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // --------------------
  // sram model
  // --------------------

  // one cycle read latency, byte-masked writes, no grant
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int a = 0; a < MemDepth; a++) begin
        sram_mem[a] <= fill_word(a);
      end
    end else if (sram_req) begin
      if (sram_write) begin
        for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
          if (sram_be[b]) begin
            sram_mem[sram_add][8*b +: 8] <= sram_wdata[8*b +: 8];
          end
        end
      end else begin
        sram_rdata <= sram_mem[sram_add];
      end
    end
  end

  // --------------------
  // reference model
  // --------------------

  task automatic expect_response(input tcdm_pkg::data_t d, input tcdm_pkg::meta_t m);
    exp_data_q.push_back(d);
    exp_meta_q.push_back(m);
  endtask

  // applies one accepted request in order of acceptance
  task automatic model_request(input logic [AddrWidth-1:0] addr, input amo_pkg::amo_op_t op,
                               input logic write, input tcdm_pkg::data_t wdata,
                               input logic [tcdm_pkg::BeWidth-1:0] be,
                               input tcdm_pkg::meta_t meta);
    tcdm_pkg::data_t old;
    logic            owner;
    logic            ok;
    old   = ref_mem[addr[2:0]];
    owner = res_valid && (res_core == meta.core_id);
    if (op == amo_pkg::AmoNone) begin
      if (write) begin
        ref_mem[addr[2:0]] = merge_bytes(old, wdata, be);
        if (res_addr == addr) begin
          res_valid = 1'b0;
        end
      end else begin
        expect_response(old, meta);
      end
    end else if (op == amo_pkg::AmoLr) begin
      expect_response(old, meta);
      // a reservation held by another core is not taken over
      if (!res_valid || owner) begin
        res_valid = 1'b1;
        res_addr  = addr;
        res_core  = meta.core_id;
      end
    end else if (op == amo_pkg::AmoSc) begin
      ok = owner && (res_addr == addr);
      if (owner) begin
        res_valid = 1'b0;
      end
      if (ok) begin
        ref_mem[addr[2:0]] = merge_bytes(old, wdata, be);
      end
      expect_response(ok ? 32'd0 : 32'd1, meta);
    end else begin
      expect_response(old, meta);
      ref_mem[addr[2:0]] = amo_result(op, old, wdata);
      if (res_addr == addr) begin
        res_valid = 1'b0;
      end
    end
  endtask

  // --------------------
  // driving and scoring
  // --------------------

  task automatic drive_ready();
    rsp_ready = hold_back ? (take_bits(2) != 32'd0) : 1'b1;
  endtask

  // inputs settled a cycle ago, handshakes fire at the coming rising edge
  task automatic observe();
    tcdm_pkg::data_t exp_data;
    tcdm_pkg::meta_t exp_meta;
    if (rsp_valid && !rsp_ready) begin
      checks++;
      if (req_ready) begin
        note_failure("in_ready_o is high while a response is held back");
      end
    end
    if (rsp_valid && rsp_ready) begin
      if (exp_data_q.size() == 0) begin
        note_failure("a response arrived with no request outstanding");
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_meta = exp_meta_q.pop_front();
        checks++;
        if (rsp_rdata !== exp_data) begin
          show_mismatch("in_rdata_o", rsp_rdata, exp_data);
        end
        if (rsp_meta !== exp_meta) begin
          show_mismatch("in_meta_o", {26'b0, rsp_meta}, {26'b0, exp_meta});
        end
      end
    end
  endtask

  // holds the request until the DUT accepts it
  task automatic issue(input logic [AddrWidth-1:0] addr, input amo_pkg::amo_op_t op,
                       input logic write, input tcdm_pkg::data_t wdata,
                       input logic [tcdm_pkg::BeWidth-1:0] be,
                       input logic [tcdm_pkg::CoreIdWidth-1:0] core);
    tcdm_pkg::meta_t meta;
    logic            taken;
    meta.core_id = core;
    meta.tag     = tag_count;
    tag_count    = tag_count + 4'd1;
    taken        = 1'b0;
    while (!taken) begin
      @(negedge clk);
      req_valid   = 1'b1;
      req_address = addr;
      req_amo     = op;
      req_write   = write;
      req_wdata   = wdata;
      req_be      = be;
      req_meta    = meta;
      drive_ready();
      #4;
      taken = req_ready;
      observe();
      if (taken) begin
        model_request(addr, op, write, wdata, be, meta);
      end
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    req_valid = 1'b0;
    drive_ready();
    #4;
    observe();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < DrainLimit) begin
      idle_cycle();
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      note_failure($sformatf("%0d responses never arrived", exp_data_q.size()));
      exp_data_q.delete();
      exp_meta_q.delete();
    end
    // extra cycles expose a duplicated response
    idle_cycle();
    idle_cycle();
  endtask

  task automatic check_memory();
    for (int a = 0; a < 8; a++) begin
      checks++;
      if (sram_mem[a] !== ref_mem[a]) begin
        show_mismatch($sformatf("sram word %0d", a), sram_mem[a], ref_mem[a]);
      end
    end
  endtask

  task automatic end_test(input string name, input int count);
    drain();
    check_memory();
    $display("test %s: %0d requests, %0d errors", name, count, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // --------------------
  // tests
  // --------------------

  initial begin
    logic [31:0]                      sel;
    logic [AddrWidth-1:0]             addr_r;
    logic [tcdm_pkg::CoreIdWidth-1:0] core_r;
    amo_pkg::amo_op_t                 op_r;
    logic [AddrWidth-1:0]             last_lr [tcdm_pkg::NumCores];
    lfsr              = 32'd73496;
    tag_count         = '0;
    hold_back         = 1'b0;
    errors            = 0;
    checks            = 0;
    test_start_errors = 0;
    rst_n             = 1'b0;
    req_valid         = 1'b0;
    req_address       = '0;
    req_amo           = amo_pkg::AmoNone;
    req_write         = 1'b0;
    req_wdata         = '0;
    req_be            = '0;
    req_meta          = '0;
    rsp_ready         = 1'b1;
    res_valid         = 1'b0;
    res_addr          = '0;
    res_core          = '0;
    for (int a = 0; a < 8; a++) begin
      ref_mem[a] = fill_word(a);
    end
    for (int c = 0; c < tcdm_pkg::NumCores; c++) begin
      last_lr[c] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // idle state straight out of reset
    @(negedge clk);
    #4;
    checks++;
    if (req_ready !== 1'b1) begin
      show_mismatch("in_ready_o", {31'b0, req_ready}, 32'd1);
    end
    if (rsp_valid !== 1'b0) begin
      show_mismatch("in_valid_o", {31'b0, rsp_valid}, 32'd0);
    end
    if (sram_req !== 1'b0 || sram_write !== 1'b0) begin
      note_failure("the SRAM port is active right after reset");
    end
    end_test("reset state", 0);

    for (int i = 0; i < NumLdSt; i++) begin
      if (take_bits(3) == 32'd0) begin
        idle_cycle();
      end
      sel    = take_bits(1);
      addr_r = rand_addr(3);
      core_r = pick_core();
      issue(addr_r, amo_pkg::AmoNone, sel[0], take_bits(32), byte_mask(), core_r);
    end
    end_test("loads and stores", NumLdSt);

    for (int i = 0; i < NumAmo; i++) begin
      sel    = take_bits(4);
      op_r   = amo_pkg::amo_op_t'(4'(sel % 9 + 1));
      addr_r = rand_addr(3);
      core_r = pick_core();
      issue(addr_r, op_r, 1'b0, take_bits(32), 4'hf, core_r);
      // reads back what the atomic left behind
      issue(addr_r, amo_pkg::AmoNone, 1'b0, '0, 4'hf, core_r);
    end
    end_test("atomics", 2 * NumAmo);

    // four words only, and sc mostly aims at its own core's last lr
    for (int i = 0; i < NumLrSc; i++) begin
      sel    = take_bits(3);
      core_r = pick_core();
      if (sel < 32'd3) begin
        addr_r          = rand_addr(2);
        last_lr[core_r] = addr_r;
        issue(addr_r, amo_pkg::AmoLr, 1'b0, '0, 4'hf, core_r);
      end else if (sel < 32'd6) begin
        addr_r = (take_bits(2) != 32'd0) ? last_lr[core_r] : rand_addr(2);
        issue(addr_r, amo_pkg::AmoSc, 1'b1, take_bits(32), 4'hf, core_r);
      end else begin
        addr_r = rand_addr(2);
        issue(addr_r, amo_pkg::AmoNone, sel == 32'd6, take_bits(32), byte_mask(), core_r);
      end
    end
    end_test("lr/sc", NumLrSc);

    // response side stalls about one cycle in four
    hold_back = 1'b1;
    for (int i = 0; i < NumMixed; i++) begin
      sel    = take_bits(2);
      addr_r = rand_addr(3);
      core_r = pick_core();
      if (sel == 32'd3) begin
        op_r = amo_pkg::amo_op_t'(4'(take_bits(4) % 9 + 1));
        issue(addr_r, op_r, 1'b0, take_bits(32), 4'hf, core_r);
      end else begin
        issue(addr_r, amo_pkg::AmoNone, sel == 32'd2, take_bits(32), byte_mask(), core_r);
      end
    end
    end_test("back-pressure", NumMixed);
    hold_back = 1'b0;

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run limit from the request count
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, the DUT stopped handshaking", cycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/tcdm_pkg.sv
common/amo_pkg.sv
hw/atomics/amo_alu.sv
hw/atomics/amo_sequencer.sv
hw/lrsc_monitor.sv
hw/resp_buffer.sv
hw/tcdm_adapter.sv
verif/tb_tcdm_adapter.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and fails when the log reports errors
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_tcdm_adapter -o tb_tcdm_adapter
./obj_dir/tb_tcdm_adapter | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
